// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert -j 0 -Wno-fatal
TOP       = obj_tb
FILELIST  = all.f
BUILD     = obj_dir

SOURCES   = $(shell cat $(FILELIST))
SIM       = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD)

// ==== all.f ====
source/obj_pkg.sv
source/obj_ram.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_line_buffer.sv
source/obj_video.sv
verification/obj_rom_model.sv
verification/obj_tb.sv

// ==== source/obj_draw.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite draw engine
// two rom fetches over req/ack, then 16 pixel writes
// into the line buffer with transparency and clipping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_draw #(
    parameter int line_width = 320
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               layer_en,
    input  logic               draw_start,
    input  obj_pkg::code_t     code,
    input  obj_pkg::xpos_t     xpos,
    input  logic [3:0]         row,
    input  logic [3:0]         palette,
    input  logic [1:0]         prio,
    input  logic               shadow,
    input  logic               hflip,
    output logic               draw_busy,
    output logic               rom_req,
    output obj_pkg::rom_addr_t rom_addr,
    input  logic               rom_ack,
    input  obj_pkg::rom_word_t rom_data,
    output logic               buf_we,
    output obj_pkg::xpos_t     buf_x,
    output obj_pkg::pixel_t    buf_pixel,
    input  logic               buf_taken
);
    import obj_pkg::*;

    draw_state_t state;
    code_t       code_q;
    xpos_t       xpos_q;
    logic [3:0]  row_q;
    logic [3:0]  pal_q;
    logic [1:0]  prio_q;
    logic        shadow_q;
    logic        hflip_q;
    logic        half;
    rom_word_t   lo_q;
    rom_word_t   hi_q;
    logic [3:0]  cnt;
    logic [3:0]  src;
    logic [63:0] row_bits;
    logic [3:0]  pen;
    logic [9:0]  x_full;

    // address only moves at request start, so it holds during req
    assign rom_addr = {code_q, row_q, half};

    // pixel 15 goes out first when flipped
    assign row_bits  = {hi_q, lo_q};
    assign src       = hflip_q ? ~cnt : cnt;
    assign pen       = row_bits[{src, 2'b00} +: 4];
    // extra bit keeps x past 511 from wrapping to the left
    assign x_full    = {1'b0, xpos_q} + cnt;
    assign buf_x     = x_full[8:0];
    assign buf_pixel = {1'b0, shadow_q, prio_q, pal_q, pen};

    // pen 0 is transparent, an earlier sprite keeps its pixel
    assign buf_we = (state == draw_write) && layer_en && (pen != 4'd0)
                    && !buf_taken && (x_full < line_width);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= draw_idle;
            draw_busy <= 1'b0;
            rom_req   <= 1'b0;
            half      <= 1'b0;
            cnt       <= '0;
        end else begin
            case (state)
                draw_idle: begin
                    if (draw_start) begin
                        code_q    <= code;
                        xpos_q    <= xpos;
                        row_q     <= row;
                        pal_q     <= palette;
                        prio_q    <= prio;
                        shadow_q  <= shadow;
                        hflip_q   <= hflip;
                        // ack is already low after the last fetch
                        half      <= 1'b0;
                        rom_req   <= 1'b1;
                        draw_busy <= 1'b1;
                        state     <= draw_req_low;
                    end
                end
                draw_req_low: begin
                    if (rom_ack) begin
                        lo_q    <= rom_data;
                        rom_req <= 1'b0;
                        state   <= draw_ack_low;
                    end
                end
                draw_ack_low: begin
                    // second fetch only once ack has dropped
                    if (!rom_ack) begin
                        half    <= 1'b1;
                        rom_req <= 1'b1;
                        state   <= draw_req_high;
                    end
                end
                draw_req_high: begin
                    if (rom_ack) begin
                        hi_q    <= rom_data;
                        rom_req <= 1'b0;
                        state   <= draw_ack_high;
                    end
                end
                draw_ack_high: begin
                    if (!rom_ack) begin
                        cnt   <= '0;
                        state <= draw_write;
                    end
                end
                draw_write: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15) begin
                        draw_busy <= 1'b0;
                        state     <= draw_idle;
                    end
                end
                default: state <= draw_idle;
            endcase
        end
    end

    // the rom may sample the address at any point of the request
    a_addr_stable: assert property (
        @(posedge clk) disable iff (reset) rom_req && $past(rom_req) |-> $stable(rom_addr)
    );

endmodule

// ==== source/obj_line_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// double line buffer
// draw half and readout half swapped on hs, readout clears
// the entry it shows, shadow rule on the pixel output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_line_buffer #(
    parameter int line_width = 320
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pxl_cen,
    input  logic            hs,
    input  obj_pkg::xpos_t  hdump,
    input  logic            shadow_en,
    input  logic            buf_we,
    input  obj_pkg::xpos_t  buf_x,
    input  obj_pkg::pixel_t buf_pixel,
    output logic            buf_taken,
    output logic [7:0]      pxl,
    output logic [1:0]      prio,
    output logic            shd
);
    import obj_pkg::*;

    // bank is the half being drawn, ~bank is read out
    logic       bank;
    logic       hs_q;
    logic       rd_en;
    logic [1:0] dirty;
    pixel_t     bank_q [2];
    pixel_t     rd_pix;
    logic       shade;

    assign rd_en = pxl_cen && (hdump < line_width);

    // one write port per half, draw writes or readout clears
    for (genvar b = 0; b < 2; b++) begin : g_bank
        pixel_t mem [line_width];
        logic   wr_side;
        xpos_t  addr;

        assign wr_side   = (bank == 1'(b));
        assign addr      = wr_side ? buf_x : hdump;
        assign bank_q[b] = mem[addr];

        always_ff @(posedge clk) begin
            if (wr_side ? buf_we : rd_en) begin
                mem[addr] <= wr_side ? buf_pixel : '0;
            end
        end
    end

    assign buf_taken = (bank_q[bank][3:0] != 4'd0);
    assign rd_pix    = bank_q[~bank];
    // pen 15 of a shadow sprite becomes a flag over a clear pixel
    assign shade     = shadow_en && rd_pix[pix_shadow_bit] && (rd_pix[3:0] == 4'hf);

    always_ff @(posedge clk) begin
        if (reset) begin
            bank  <= 1'b0;
            hs_q  <= 1'b0;
            // neither half has been cleared by a readout yet
            dirty <= 2'b11;
            pxl   <= '0;
            prio  <= '0;
            shd   <= 1'b0;
        end else begin
            hs_q <= hs;
            if (hs && !hs_q) begin
                bank        <= ~bank;
                dirty[~bank] <= 1'b0;
            end
            if (pxl_cen) begin
                if (rd_en && !dirty[~bank]) begin
                    pxl  <= {rd_pix[7:4], shade ? 4'd0 : rd_pix[3:0]};
                    prio <= rd_pix[9:8];
                    shd  <= shade;
                end else begin
                    pxl  <= '0;
                    prio <= '0;
                    shd  <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/obj_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object layer package
// value widths, sprite table layout, line buffer fields
// and the state types of the scanner and draw FSMs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package obj_pkg;

    // object ram holds 128 sprites of 4 words
    localparam int ram_aw_default = 9;

    typedef logic [ram_aw_default-1:0] obj_addr_t;
    typedef logic [15:0]               word_t;
    typedef logic [11:0]               code_t;
    // rom word address is code, row, then half select
    typedef logic [$bits(code_t)+4:0]  rom_addr_t;
    // eight pens, leftmost pixel in the low nibble
    typedef logic [31:0]               rom_word_t;
    typedef logic [8:0]                xpos_t;
    typedef logic [8:0]                ypos_t;
    // spare, shadow, priority[1:0], palette[3:0], pen[3:0]
    typedef logic [11:0]               pixel_t;

    // word offsets inside one sprite entry
    localparam logic [1:0] spr_word_y    = 2'd0;
    localparam logic [1:0] spr_word_x    = 2'd1;
    localparam logic [1:0] spr_word_code = 2'd2;
    localparam logic [1:0] spr_word_attr = 2'd3;

    // y word: visible flag on top, y in bits 8:0
    localparam int spr_visible_bit = 15;
    // attr word: palette 3:0, priority 5:4
    localparam int attr_shadow_bit = 6;
    localparam int attr_hflip_bit  = 7;

    // sprites are 16x16
    localparam int spr_size = 16;

    // shadow flag position inside a line buffer entry
    localparam int pix_shadow_bit = 10;

    typedef enum logic [2:0] {
        scan_idle,
        scan_read_y,
        scan_read_rest,
        scan_request,
        scan_wait_draw,
        scan_done
    } scan_state_t;

    typedef enum logic [2:0] {
        draw_idle,
        draw_req_low,
        draw_ack_low,
        draw_req_high,
        draw_ack_high,
        draw_write
    } draw_state_t;

endpackage

// ==== source/obj_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-port object RAM
// cpu read/write port and a read-only scanner port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_ram #(
    parameter int ram_aw = 9
) (
    input  logic              clk,
    input  logic              cpu_we,
    input  logic [ram_aw-1:0] cpu_addr,
    input  obj_pkg::word_t    cpu_din,
    output obj_pkg::word_t    cpu_dout,
    input  logic [ram_aw-1:0] scan_addr,
    output obj_pkg::word_t    scan_data
);
    import obj_pkg::*;

    word_t mem [2**ram_aw];

    // cpu side, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_dout <= mem[cpu_addr];
    end

    // scanner side
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

    // a write with an unknown address would corrupt the table
    // that the scanner walks on the other port
    a_addr_known: assert property (
        @(posedge clk) cpu_we |-> !$isunknown(cpu_addr) && !$isunknown(scan_addr)
    );

endmodule

// ==== source/obj_scan.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object scanner
// control register and per-line walk of the sprite table,
// issuing one draw request per sprite on the next line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_scan #(
    parameter int ram_aw       = 9,
    parameter int sprite_count = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              hs,
    input  obj_pkg::ypos_t    vdump,
    input  logic              reg_we,
    input  logic [1:0]        reg_din,
    output logic              shadow_en,
    output logic [ram_aw-1:0] scan_addr,
    input  obj_pkg::word_t    scan_data,
    output logic              draw_start,
    input  logic              draw_busy,
    output obj_pkg::code_t    code,
    output obj_pkg::xpos_t    xpos,
    output logic [3:0]        row,
    output logic [3:0]        palette,
    output logic [1:0]        prio,
    output logic              shadow,
    output logic              hflip,
    output logic              layer_en
);
    import obj_pkg::*;

    // sprite index bits above the word select
    localparam int iw = ram_aw - 2;

    scan_state_t   state;
    logic          hs_q;
    logic [iw-1:0] idx;
    logic [1:0]    wsel;
    logic [1:0]    rd_sel;
    logic          data_ok;
    ypos_t         line_q;
    ypos_t         dy;
    logic          hit;
    logic          last;

    assign scan_addr = {idx, wsel};
    // row of the sprite that falls on the target line
    assign dy   = line_q - scan_data[8:0];
    assign hit  = scan_data[spr_visible_bit] && (dy < spr_size);
    assign last = (idx == iw'(sprite_count - 1));

    // bit 0 layer enable, bit 1 shadow enable
    always_ff @(posedge clk) begin
        if (reset) begin
            layer_en  <= 1'b0;
            shadow_en <= 1'b0;
        end else if (reg_we) begin
            layer_en  <= reg_din[0];
            shadow_en <= reg_din[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= scan_idle;
            hs_q       <= 1'b0;
            idx        <= '0;
            wsel       <= spr_word_y;
            rd_sel     <= spr_word_y;
            data_ok    <= 1'b0;
            draw_start <= 1'b0;
            line_q     <= '0;
        end else begin
            hs_q       <= hs;
            draw_start <= 1'b0;
            if (hs && !hs_q) begin
                // new line, any walk still running is dropped
                line_q  <= vdump + 1'b1;
                idx     <= '0;
                wsel    <= spr_word_y;
                data_ok <= 1'b0;
                state   <= scan_read_y;
            end else begin
                case (state)
                    scan_read_y: begin
                        // first cycle waits for the ram read
                        data_ok <= ~data_ok;
                        if (data_ok) begin
                            if (hit) begin
                                row   <= dy[3:0];
                                wsel  <= spr_word_x;
                                state <= scan_read_rest;
                            end else if (last) begin
                                state <= scan_done;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= scan_read_y;
                            end
                        end
                    end
                    scan_read_rest: begin
                        // addresses x, code, attr back to back
                        // data trails the address by one cycle
                        data_ok <= 1'b1;
                        rd_sel  <= wsel;
                        if (wsel != spr_word_attr) begin
                            wsel <= wsel + 1'b1;
                        end
                        if (data_ok) begin
                            case (rd_sel)
                                spr_word_x:    xpos <= scan_data[8:0];
                                spr_word_code: code <= scan_data[11:0];
                                default: begin
                                    palette <= scan_data[3:0];
                                    prio    <= scan_data[5:4];
                                    shadow  <= scan_data[attr_shadow_bit];
                                    hflip   <= scan_data[attr_hflip_bit];
                                    data_ok <= 1'b0;
                                    state   <= scan_request;
                                end
                            endcase
                        end
                    end
                    scan_request: begin
                        if (!draw_busy) begin
                            draw_start <= 1'b1;
                            state      <= scan_wait_draw;
                        end
                    end
                    scan_wait_draw: begin
                        // engine has taken the request once busy shows
                        if (draw_busy) begin
                            wsel <= spr_word_y;
                            if (last) begin
                                state <= scan_done;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= scan_read_y;
                            end
                        end
                    end
                    // idle and done wait for the next hs
                    default: ;
                endcase
            end
        end
    end

    // a request only goes out to an engine that is free
    a_start_free: assert property (
        @(posedge clk) disable iff (reset) draw_start |-> !draw_busy
    );

endmodule

// ==== source/obj_video.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object layer top level
// object ram, scanner, draw engine and line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_video #(
    parameter int ram_aw       = $bits(obj_pkg::obj_addr_t),
    parameter int sprite_count = 32,
    parameter int line_width   = 320
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  obj_pkg::xpos_t     hdump,
    input  obj_pkg::ypos_t     vdump,
    input  logic               hs,
    // cpu access
    input  logic               ram_cs,
    input  logic               ram_we,
    input  logic [ram_aw-1:0]  ram_addr,
    input  obj_pkg::word_t     ram_din,
    output obj_pkg::word_t     cpu_dout,
    input  logic               reg_cs,
    input  logic               reg_we,
    input  logic [1:0]         reg_din,
    // graphics rom
    output logic               rom_req,
    output obj_pkg::rom_addr_t rom_addr,
    input  logic               rom_ack,
    input  obj_pkg::rom_word_t rom_data,
    // pixel output
    output logic [7:0]         pxl,
    output logic [1:0]         prio,
    output logic               shd
);
    import obj_pkg::*;

    logic [ram_aw-1:0] scan_addr;
    word_t             scan_data;
    logic              draw_start;
    logic              draw_busy;
    code_t             code;
    xpos_t             xpos;
    logic [3:0]        row;
    logic [3:0]        palette;
    logic [1:0]        spr_prio;
    logic              shadow;
    logic              hflip;
    logic              layer_en;
    logic              shadow_en;
    logic              buf_we;
    xpos_t             buf_x;
    pixel_t            buf_pixel;
    logic              buf_taken;

    obj_ram #(
        .ram_aw    (ram_aw)
    ) u_ram (
        .clk       (clk),
        .cpu_we    (ram_cs & ram_we),
        .cpu_addr  (ram_addr),
        .cpu_din   (ram_din),
        .cpu_dout  (cpu_dout),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    obj_scan #(
        .ram_aw       (ram_aw),
        .sprite_count (sprite_count)
    ) u_scan (
        .clk        (clk),
        .reset      (reset),
        .hs         (hs),
        .vdump      (vdump),
        .reg_we     (reg_cs & reg_we),
        .reg_din    (reg_din),
        .shadow_en  (shadow_en),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data),
        .draw_start (draw_start),
        .draw_busy  (draw_busy),
        .code       (code),
        .xpos       (xpos),
        .row        (row),
        .palette    (palette),
        .prio       (spr_prio),
        .shadow     (shadow),
        .hflip      (hflip),
        .layer_en   (layer_en)
    );

    obj_draw #(
        .line_width (line_width)
    ) u_draw (
        .clk        (clk),
        .reset      (reset),
        .layer_en   (layer_en),
        .draw_start (draw_start),
        .code       (code),
        .xpos       (xpos),
        .row        (row),
        .palette    (palette),
        .prio       (spr_prio),
        .shadow     (shadow),
        .hflip      (hflip),
        .draw_busy  (draw_busy),
        .rom_req    (rom_req),
        .rom_addr   (rom_addr),
        .rom_ack    (rom_ack),
        .rom_data   (rom_data),
        .buf_we     (buf_we),
        .buf_x      (buf_x),
        .buf_pixel  (buf_pixel),
        .buf_taken  (buf_taken)
    );

    obj_line_buffer #(
        .line_width (line_width)
    ) u_buf (
        .clk        (clk),
        .reset      (reset),
        .pxl_cen    (pxl_cen),
        .hs         (hs),
        .hdump      (hdump),
        .shadow_en  (shadow_en),
        .buf_we     (buf_we),
        .buf_x      (buf_x),
        .buf_pixel  (buf_pixel),
        .buf_taken  (buf_taken),
        .pxl        (pxl),
        .prio       (prio),
        .shd        (shd)
    );

endmodule

// ==== verification/obj_rom_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// graphics rom model
// four-phase req/ack responder with random latency,
// data is a fixed hash of the word address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_rom_model #(
    parameter logic [31:0] seed = 32'h11d5
) (
    input  logic               clk,
    input  logic               rom_req,
    input  obj_pkg::rom_addr_t rom_addr,
    output logic               rom_ack,
    output obj_pkg::rom_word_t rom_data
);
    timeunit 1ns;
    timeprecision 1ns;
    import obj_pkg::*;

    logic [31:0] rng;
    int          delay;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // mixed so that every pen value turns up, 0 and 15 included
    function automatic rom_word_t rom_contents(input rom_addr_t a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h2c1b3c6d;
        h = h ^ (h >> 12);
        return h;
    endfunction

    initial begin
        rng      = seed;
        delay    = 1;
        rom_ack  = 1'b0;
        rom_data = '0;
    end

    // answers on the falling edge, like the rest of the stimulus
    always @(negedge clk) begin
        if (rom_req && !rom_ack) begin
            if (delay <= 1) begin
                rom_data <= rom_contents(rom_addr);
                rom_ack  <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end else if (!rom_req && rom_ack) begin
            rom_ack <= 1'b0;
            // 1 to 4 cycles for the next request
            delay   <= 1 + int'(next_random() % 4);
        end
    end

endmodule

// ==== verification/obj_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object layer testbench
// clock, reset, video timing, random sprite tables,
// reference model of the layer, checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module obj_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import obj_pkg::*;

    localparam int clk_period   = 100;
    localparam int line_width   = 320;
    localparam int line_len     = 384;
    localparam int hs_pos       = 352;
    localparam int frame_lines  = 32;
    localparam int sprite_count = 32;
    // two clocks per pixel
    localparam int frame_cycles = 2 * line_len * frame_lines;
    // each table round stays under two frames, ram test under one
    localparam int round_count  = 11;
    localparam int limit_frames = 2 * round_count + 1 + 2;

    logic       clk;
    logic       reset;
    logic       pxl_cen = 1'b0;
    xpos_t      hdump = '0;
    ypos_t      vdump = '0;
    logic       hs;
    logic       ram_cs;
    logic       ram_we;
    logic [8:0] ram_addr;
    word_t      ram_din;
    word_t      cpu_dout;
    logic       reg_cs;
    logic       reg_we;
    logic [1:0] reg_din;
    logic       rom_req;
    rom_addr_t  rom_addr;
    logic       rom_ack;
    rom_word_t  rom_data;
    logic [7:0] pxl;
    logic [1:0] prio;
    logic       shd;

    // copy of the object ram, the first 128 words are the table
    word_t       ram_copy [512];
    logic [1:0]  ctl;
    logic        check_on = 1'b0;
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests;

    obj_video #(
        .ram_aw       (9),
        .sprite_count (sprite_count),
        .line_width   (line_width)
    ) dut0 (
        .clk (clk), .reset (reset), .pxl_cen (pxl_cen), .hdump (hdump), .vdump (vdump),
        .hs (hs), .ram_cs (ram_cs), .ram_we (ram_we), .ram_addr (ram_addr),
        .ram_din (ram_din), .cpu_dout (cpu_dout), .reg_cs (reg_cs), .reg_we (reg_we),
        .reg_din (reg_din), .rom_req (rom_req), .rom_addr (rom_addr), .rom_ack (rom_ack),
        .rom_data (rom_data), .pxl (pxl), .prio (prio), .shd (shd)
    );

    obj_rom_model #(
        .seed (32'h11d5)
    ) rom0 (
        .clk (clk), .rom_req (rom_req), .rom_addr (rom_addr),
        .rom_ack (rom_ack), .rom_data (rom_data)
    );

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // same address hash as the rom responder
    function automatic rom_word_t gfx_word(input rom_addr_t a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h2c1b3c6d;
        h = h ^ (h >> 12);
        return h;
    endfunction

    // {shd, prio, palette, pen} shown at line d, pixel x
    // line d shows the sprites of line d-1, lowest index in front
    function automatic logic [10:0] expect_pixel(input int d, input int x);
        int         t;
        int         dy;
        int         p;
        word_t      yw;
        word_t      aw;
        rom_word_t  w;
        logic [3:0] pen;
        t = ((d + frame_lines - 2) % frame_lines) + 1;
        if (!ctl[0]) begin
            return '0;
        end
        for (int i = 0; i < sprite_count; i++) begin
            yw = ram_copy[4 * i];
            aw = ram_copy[4 * i + 3];
            dy = (t - int'(yw[8:0]) + 512) % 512;
            p  = x - int'(ram_copy[4 * i + 1][8:0]);
            if (yw[15] && dy < spr_size && p >= 0 && p < spr_size) begin
                if (aw[7]) begin
                    p = 15 - p;
                end
                w   = gfx_word({ram_copy[4 * i + 2][11:0], 4'(dy), p >= 8});
                pen = w[(p % 8) * 4 +: 4];
                // shadow pen keeps its palette but clears the pen
                if (pen != 4'd0 && ctl[1] && aw[6] && pen == 4'hf) begin
                    return {1'b1, aw[5:4], aw[3:0], 4'h0};
                end else if (pen != 4'd0) begin
                    return {1'b0, aw[5:4], aw[3:0], pen};
                end
            end
        end
        return '0;
    endfunction

    task automatic compare_pixel(input int d, input int x);
        logic [10:0] want;
        want = expect_pixel(d, x);
        checks++;
        a_pxl: assert (pxl == want[7:0]) else begin
            $display("FAIL %0t pxl line %0d x %0d: got %h expected %h",
                     $time, d, x, pxl, want[7:0]);
            errors++;
        end
        a_prio: assert (prio == want[9:8]) else begin
            $display("FAIL %0t prio line %0d x %0d: got %h expected %h",
                     $time, d, x, prio, want[9:8]);
            errors++;
        end
        a_shd: assert (shd == want[10]) else begin
            $display("FAIL %0t shd line %0d x %0d: got %b expected %b",
                     $time, d, x, shd, want[10]);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // hs sits on hdump 352 for one pixel
    assign hs = (hdump == xpos_t'(hs_pos));

    // pixel enable every second cycle, outputs checked while stable
    always @(negedge clk) begin
        if (pxl_cen && check_on && hdump < line_width) begin
            compare_pixel(int'(vdump), int'(hdump));
        end
        if (pxl_cen && hdump == xpos_t'(line_len - 1)) begin
            hdump <= '0;
            vdump <= (vdump == ypos_t'(frame_lines - 1)) ? '0 : vdump + 1'b1;
        end else if (pxl_cen) begin
            hdump <= hdump + 1'b1;
        end
        pxl_cen <= ~pxl_cen;
    end

    task automatic write_word(input int a, input word_t d);
        @(negedge clk);
        ram_cs   <= 1'b1;
        ram_we   <= 1'b1;
        ram_addr <= 9'(a);
        ram_din  <= d;
    endtask

    // random writes, then reads in a pipeline, data one cycle later
    task automatic ram_test();
        int addr_list [64];
        int a;
        for (int i = 0; i < 64; i++) begin
            a            = int'(next_random() % 512);
            addr_list[i] = a;
            ram_copy[a]  = word_t'(next_random());
            write_word(a, ram_copy[a]);
        end
        for (int i = 0; i <= 64; i++) begin
            @(negedge clk);
            if (i > 0) begin
                checks++;
                a_dout: assert (cpu_dout == ram_copy[addr_list[i - 1]]) else begin
                    $display("FAIL %0t cpu_dout: got %h expected %h",
                             $time, cpu_dout, ram_copy[addr_list[i - 1]]);
                    errors++;
                end
            end
            ram_we   <= 1'b0;
            ram_cs   <= (i < 64);
            ram_addr <= 9'(addr_list[i % 64]);
        end
    endtask

    // hidden random entries plus up to n_vis visible sprites
    task automatic load_round(input int n_vis, input int x_lo, input int x_span,
                              input int y_lo, input int y_span, input word_t attr_or,
                              input logic [1:0] ctl_val);
        int    idx;
        word_t r;
        for (int a = 0; a < 4 * sprite_count; a++) begin
            r = word_t'(next_random());
            if (a % 4 == 0) begin
                r[15] = 1'b0;
            end
            ram_copy[a] = r;
        end
        for (int n = 0; n < n_vis; n++) begin
            idx = int'(next_random() % sprite_count);
            ram_copy[4 * idx]     = 16'h8000 | word_t'(y_lo + int'(next_random() % y_span));
            ram_copy[4 * idx + 1] = word_t'(x_lo + int'(next_random() % x_span));
            ram_copy[4 * idx + 3] = ram_copy[4 * idx + 3] | attr_or;
        end
        for (int a = 0; a < 4 * sprite_count; a++) begin
            write_word(a, ram_copy[a]);
        end
        @(negedge clk);
        ram_cs  <= 1'b0;
        ram_we  <= 1'b0;
        reg_cs  <= 1'b1;
        reg_we  <= 1'b1;
        reg_din <= ctl_val;
        ctl      = ctl_val;
        @(negedge clk);
        reg_cs <= 1'b0;
        reg_we <= 1'b0;
        // first hs draws the new table, the second shows it
        repeat (2) @(posedge hs);
        check_on = 1'b1;
        repeat (frame_lines) @(posedge hs);
        check_on = 1'b0;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    initial begin
        int start;
        int xb;
        int yb;
        rng      = 32'h11d5;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        ctl      = 2'b00;
        ram_cs   = 1'b0;
        ram_we   = 1'b0;
        ram_addr = '0;
        ram_din  = '0;
        reg_cs   = 1'b0;
        reg_we   = 1'b0;
        reg_din  = '0;
        reset    = 1'b1;
        repeat (3) @(negedge clk);
        reset <= 1'b0;

        start = errors;
        ram_test();
        end_test("cpu ram access", start);

        start = errors;
        load_round(1, 0, 305, 0, 30, 16'h0000, {next_random() % 2 == 1, 1'b1});
        load_round(1, 0, 305, 0, 30, 16'h0080, 2'b01);
        // right edge clipping
        load_round(1, 306, 14, 0, 30, 16'h0000, 2'b01);
        // tail runs past x 511 and would wrap onto the left edge
        load_round(1, 497, 15, 0, 30, 16'h0000, 2'b01);
        end_test("single sprite", start);

        start = errors;
        repeat (2) begin
            xb = int'(next_random() % 290);
            yb = int'(next_random() % 20);
            load_round(4, xb, 12, yb, 6, 16'h0000, 2'b01);
        end
        end_test("overlap order", start);

        start = errors;
        load_round(4, 0, 305, 0, 30, 16'h0040, 2'b11);
        load_round(4, 0, 305, 0, 30, 16'h0040, 2'b01);
        end_test("shadow pen", start);

        start = errors;
        load_round(4, 0, 305, 0, 30, 16'h0000, 2'b00);
        end_test("layer disable", start);

        start = errors;
        // full lines at the top, then an empty table
        load_round(4, 0, 305, 0, 12, 16'h0000, 2'b01);
        load_round(0, 0, 1, 0, 1, 16'h0000, 2'b01);
        end_test("blank lines", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the frames that the tests need
    initial begin
        #(limit_frames * frame_cycles * clk_period);
        $display("timeout: tests did not finish within %0d frames", limit_frames);
        $display("Testbench failed");
        $finish;
    end

endmodule
